// ==== fabric_config.svh ====
`ifndef FABRIC_CONFIG_SVH
`define FABRIC_CONFIG_SVH

//////////////////////////////////////////////////
// Port geometry

// Switch ports on the fabric
`define FABRIC_NUM_PORTS 15
// Width of a port index
`define FABRIC_PORT_BITS 4

//////////////////////////////////////////////////
// Frame and VLAN widths

`define FABRIC_DATA_BITS 128
`define FABRIC_VLAN_BITS 12
// Longest legal frame in beats
`define FABRIC_MAX_FRAME_BEATS 4

//////////////////////////////////////////////////
// Exit queue sizing

`define FABRIC_QUEUE_DEPTH 16
// Two frames of slack to ride out the space flag lag
`define FABRIC_SPACE_THRESHOLD (2 * `FABRIC_MAX_FRAME_BEATS)

`endif

// ==== fabric_pkg.sv ====
`include "fabric_config.svh"

package fabric_pkg;

	//////////////////////////////////////////////////
	// Basic fabric types

	// One bit per switch port
	typedef logic [`FABRIC_NUM_PORTS-1:0] port_mask_t;

	// 802.1q VLAN ID
	typedef logic [`FABRIC_VLAN_BITS-1:0] vlan_t;

	//////////////////////////////////////////////////
	// Stream beats

	// One beat on any frame stream
	typedef struct packed {
		// Set on the final beat of a frame
		logic last;
		logic [`FABRIC_DATA_BITS-1:0] data;
	} frame_beat_t;

	// Sideband carried with the first beat of a frame
	typedef struct packed {
		// Ingress port the frame came in on
		logic [`FABRIC_PORT_BITS-1:0] src_port;
		vlan_t vlan;
	} frame_header_t;

	//////////////////////////////////////////////////
	// Forwarding FSM

	typedef enum logic [1:0] {
		// Waiting for the first beat of a frame
		FWD_IDLE,
		// Copying beats to the chosen ports
		FWD_COPY,
		// Discarding a frame with no destination
		FWD_DROP
	} fwd_state_t;

endpackage

// ==== forwarding_engine.sv ====
`timescale 1ns/1ps
`include "fabric_config.svh"

module forwarding_engine import fabric_pkg::*; (
	input logic clk_ram_ctl,
	input logic rst,

	// Inbound frame stream, no back-pressure
	input logic frame_valid,
	input frame_beat_t frame_beat,
	input frame_header_t frame_header,

	// Per-port forwarding config
	input vlan_t [`FABRIC_NUM_PORTS-1:0] port_vlan,
	input port_mask_t port_trunk,

	// Space flags from the exit queues
	input port_mask_t space_avail,

	// Write side of the exit queues
	output port_mask_t port_wr,
	output frame_beat_t wr_beat
);

	//////////////////////////////////////////////////
	// Space flag pipeline

	// Registered copy of the queue flags
	port_mask_t space_ff;

	// Extra register stage for timing
	// Threshold slack in the queues covers the added lag
	always_ff @(posedge clk_ram_ctl) begin
		if (rst) begin
			space_ff <= '0;
		end else begin
			space_ff <= space_avail;
		end
	end

	//////////////////////////////////////////////////
	// Destination lookup

	// Candidate ports for the frame now starting
	port_mask_t dest_mask;

	always_comb begin
		for (int p = 0; p < `FABRIC_NUM_PORTS; p++) begin
			// Never hairpin back to the ingress port
			// Trunks take every VLAN, access ports only their own
			// Skip ports that are short on space
			dest_mask[p] = (frame_header.src_port != `FABRIC_PORT_BITS'(p)) &&
				(port_trunk[p] || (port_vlan[p] == frame_header.vlan)) &&
				space_ff[p];
		end
	end

	//////////////////////////////////////////////////
	// Forwarding FSM

	fwd_state_t state;
	fwd_state_t state_next;

	// Destination set latched for the whole frame
	port_mask_t frame_mask;

	// Next state logic
	always_comb begin
		state_next = state;
		case (state)
			FWD_IDLE: begin
				// Single beat frames finish right away
				if (frame_valid && !frame_beat.last) begin
					if (dest_mask == '0) begin
						state_next = FWD_DROP;
					end else begin
						state_next = FWD_COPY;
					end
				end
			end
			FWD_COPY, FWD_DROP: begin
				if (frame_valid && frame_beat.last) begin
					state_next = FWD_IDLE;
				end
			end
			default: begin
				state_next = FWD_IDLE;
			end
		endcase
	end

	// State, latched mask and write strobes
	always_ff @(posedge clk_ram_ctl) begin
		if (rst) begin
			state <= FWD_IDLE;
			frame_mask <= '0;
			port_wr <= '0;
		end else begin
			state <= state_next;

			// Strobes are single cycle by default
			port_wr <= '0;

			if (frame_valid) begin
				case (state)
					FWD_IDLE: begin
						// First beat picks the ports for the frame
						frame_mask <= dest_mask;
						port_wr <= dest_mask;
					end
					FWD_COPY: begin
						port_wr <= frame_mask;
					end
					default: begin
						// Dropped beats go nowhere
						port_wr <= '0;
					end
				endcase
			end
		end
	end

	// Beat goes out alongside its write strobe
	always_ff @(posedge clk_ram_ctl) begin
		if (frame_valid) begin
			wr_beat <= frame_beat;
		end
	end

endmodule

// ==== exit_queue.sv ====
`timescale 1ns/1ps
`include "fabric_config.svh"

module exit_queue import fabric_pkg::*; (
	input logic clk_ram_ctl,
	input logic rst,

	// Port link state, queue is flushed while low
	input logic link_up,

	// Write side from the forwarding engine
	input logic wr,
	input frame_beat_t wr_beat,
	output logic space_avail,

	// Transmit side toward the MAC
	output logic tx_valid,
	output frame_beat_t tx_beat,
	input logic tx_ready
);

	//////////////////////////////////////////////////
	// Sizing

	localparam int PTR_BITS = $clog2(`FABRIC_QUEUE_DEPTH);
	localparam int CNT_BITS = $clog2(`FABRIC_QUEUE_DEPTH + 1);

	// Fill level of a full queue
	localparam logic [CNT_BITS-1:0] FULL_LEVEL = CNT_BITS'(`FABRIC_QUEUE_DEPTH);

	// Highest fill level that still leaves enough room for a new frame
	localparam logic [CNT_BITS-1:0] SPACE_LEVEL =
		CNT_BITS'(`FABRIC_QUEUE_DEPTH - `FABRIC_SPACE_THRESHOLD);

	// Advance a pointer with wrap at the end of storage
	function automatic logic [PTR_BITS-1:0] ptr_inc(input logic [PTR_BITS-1:0] ptr);
		if (ptr == PTR_BITS'(`FABRIC_QUEUE_DEPTH - 1)) begin
			return '0;
		end
		return ptr + PTR_BITS'(1);
	endfunction

	//////////////////////////////////////////////////
	// Storage and pointers

	frame_beat_t mem [`FABRIC_QUEUE_DEPTH];

	logic [PTR_BITS-1:0] wr_ptr;
	logic [PTR_BITS-1:0] rd_ptr;
	logic [CNT_BITS-1:0] count;
	logic [CNT_BITS-1:0] count_next;

	logic push;
	logic pop;

	// Head of queue falls through to the transmit side
	assign tx_valid = (count != '0);
	assign tx_beat = mem[rd_ptr];

	assign pop = tx_valid && tx_ready;

	// Writes to a dead link are discarded
	// A full queue only takes a beat if one leaves in the same cycle
	assign push = wr && link_up && ((count != FULL_LEVEL) || pop);

	// Fill level after this cycle
	always_comb begin
		count_next = count;
		if (!link_up) begin
			count_next = '0;
		end else if (push && !pop) begin
			count_next = count + CNT_BITS'(1);
		end else if (pop && !push) begin
			count_next = count - CNT_BITS'(1);
		end
	end

	//////////////////////////////////////////////////
	// Control registers

	always_ff @(posedge clk_ram_ctl) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			space_avail <= 1'b0;
		end else begin
			count <= count_next;

			// Tracks the new fill level, so no extra lag here
			space_avail <= link_up && (count_next <= SPACE_LEVEL);

			if (!link_up) begin
				// Hold the queue empty until the link comes back
				wr_ptr <= '0;
				rd_ptr <= '0;
			end else begin
				if (push) begin
					wr_ptr <= ptr_inc(wr_ptr);
				end
				if (pop) begin
					rd_ptr <= ptr_inc(rd_ptr);
				end
			end
		end
	end

	// Beat storage
	always_ff @(posedge clk_ram_ctl) begin
		if (push) begin
			mem[wr_ptr] <= wr_beat;
		end
	end

endmodule

// ==== switch_fabric.sv ====
`timescale 1ns/1ps
`include "fabric_config.svh"

module switch_fabric import fabric_pkg::*; (
	input logic clk_ram_ctl,
	input logic rst,

	// Frames coming out of the ingress buffer
	input logic frame_valid,
	input frame_beat_t frame_beat,
	input frame_header_t frame_header,

	// Per-port config and status
	input vlan_t [`FABRIC_NUM_PORTS-1:0] port_vlan,
	input port_mask_t port_trunk,
	input port_mask_t port_link_up,

	// Egress streams, one per port
	input port_mask_t port_tx_ready,
	output port_mask_t port_tx_valid,
	output frame_beat_t [`FABRIC_NUM_PORTS-1:0] port_tx_beat
);

	//////////////////////////////////////////////////
	// Engine to queue wiring

	// Per-port write strobes
	port_mask_t port_wr;

	// Beat shared by all queues
	frame_beat_t wr_beat;

	// Room flags back to the engine
	port_mask_t space_avail;

	//////////////////////////////////////////////////
	// Forwarding engine

	forwarding_engine i_forwarding_engine (
		.clk_ram_ctl(clk_ram_ctl),
		.rst(rst),

		.frame_valid(frame_valid),
		.frame_beat(frame_beat),
		.frame_header(frame_header),

		.port_vlan(port_vlan),
		.port_trunk(port_trunk),

		.space_avail(space_avail),

		.port_wr(port_wr),
		.wr_beat(wr_beat)
	);

	//////////////////////////////////////////////////
	// Exit queues

	// One FIFO per egress port
	for (genvar p = 0; p < `FABRIC_NUM_PORTS; p++) begin : g_exit_queue
		exit_queue i_exit_queue (
			.clk_ram_ctl(clk_ram_ctl),
			.rst(rst),

			.link_up(port_link_up[p]),

			// Every queue sees the same beat, only its strobe differs
			.wr(port_wr[p]),
			.wr_beat(wr_beat),
			.space_avail(space_avail[p]),

			.tx_valid(port_tx_valid[p]),
			.tx_beat(port_tx_beat[p]),
			.tx_ready(port_tx_ready[p])
		);
	end

endmodule

// ==== tb_switch_fabric.sv ====
`timescale 1ns/1ps
`include "fabric_config.svh"

module tb_switch_fabric import fabric_pkg::*; ();

	localparam int NP = `FABRIC_NUM_PORTS;

	//////////////////////////////////////////////////
	// DUT signals

	logic clk_ram_ctl;
	logic rst;
	logic frame_valid;
	frame_beat_t frame_beat;
	frame_header_t frame_header;
	vlan_t [NP-1:0] port_vlan;
	port_mask_t port_trunk;
	port_mask_t port_link_up;
	port_mask_t port_tx_ready;
	port_mask_t port_tx_valid;
	frame_beat_t [NP-1:0] port_tx_beat;

	// Shared stimulus seed
	integer seed;

	// Snapshots of output beat counts
	int out_before;
	int port9_before;
	int port13_before;

	// High while the ready pattern is being randomized
	bit sending;

	switch_fabric i_switch_fabric (
		.clk_ram_ctl(clk_ram_ctl),
		.rst(rst),
		.frame_valid(frame_valid),
		.frame_beat(frame_beat),
		.frame_header(frame_header),
		.port_vlan(port_vlan),
		.port_trunk(port_trunk),
		.port_link_up(port_link_up),
		.port_tx_ready(port_tx_ready),
		.port_tx_valid(port_tx_valid),
		.port_tx_beat(port_tx_beat)
	);

	// 20 ns clock
	initial begin
		clk_ram_ctl = 1'b0;
		forever #10 clk_ram_ctl = ~clk_ram_ctl;
	end

	//////////////////////////////////////////////////
	// Failure reporting

	task automatic flag_mismatch(input string name, input logic [159:0] got,
		input logic [159:0] expected);
		$display("** Error: %s = 0x%h, expected 0x%h", name, got, expected);
		$display("tests failed");
		$fatal(1, "Value check failed on %s", name);
	endtask

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("tests failed");
		$fatal(1, "Run aborted");
	endtask

	//////////////////////////////////////////////////
	// Reference model

	// Expected beats per exit queue, head at index 0
	frame_beat_t exp_q [NP][$];
	// Model of the engine write strobes and beat
	port_mask_t model_wr;
	frame_beat_t model_beat;
	// Queue space flag and the engine's registered copy
	port_mask_t model_space;
	port_mask_t model_space_ff;
	// Destination set of the frame in progress
	port_mask_t model_mask;
	logic model_in_frame;
	// Beats seen leaving each port
	int beats_out [NP];

	// Forwarding rule applied to a new frame
	function automatic port_mask_t expected_dest(input frame_header_t hdr);
		port_mask_t m;
		for (int p = 0; p < NP; p++) begin
			m[p] = (int'(hdr.src_port) != p) &&
				(port_trunk[p] || (port_vlan[p] == hdr.vlan)) && model_space_ff[p];
		end
		return m;
	endfunction

	function automatic int total_beats_out();
		int sum;
		sum = 0;
		for (int p = 0; p < NP; p++) begin
			sum += beats_out[p];
		end
		return sum;
	endfunction

	// Reads pre-edge values, so it sees what the DUT registers see
	always @(posedge clk_ram_ctl) begin
		if (rst) begin
			for (int p = 0; p < NP; p++) begin
				exp_q[p].delete();
				beats_out[p] = 0;
			end
			model_wr = '0;
			model_space = '0;
			model_space_ff = '0;
			model_mask = '0;
			model_in_frame = 1'b0;
		end else begin
			// Transmit side against the expected queues
			for (int p = 0; p < NP; p++) begin
				assert (port_tx_valid[p] == (exp_q[p].size() != 0))
					else flag_mismatch($sformatf("port_tx_valid[%0d]", p),
						port_tx_valid[p], exp_q[p].size() != 0);
				if (port_tx_valid[p] && port_tx_ready[p]) begin
					assert (port_tx_beat[p] == exp_q[p][0])
						else flag_mismatch($sformatf("port_tx_beat[%0d]", p),
							port_tx_beat[p], exp_q[p][0]);
					void'(exp_q[p].pop_front());
					beats_out[p]++;
				end
			end
			// Writes strobed by the engine in the cycle before
			for (int p = 0; p < NP; p++) begin
				if (!port_link_up[p]) begin
					exp_q[p].delete();
				end else if (model_wr[p]) begin
					assert (exp_q[p].size() < `FABRIC_QUEUE_DEPTH)
						else abort_run($sformatf("Beat lost, exit queue %0d was full", p));
					exp_q[p].push_back(model_beat);
				end
			end
			// Engine, mask picked on the first beat and held to the last
			model_wr = '0;
			if (frame_valid) begin
				if (!model_in_frame) begin
					model_mask = expected_dest(frame_header);
				end
				model_wr = model_mask;
				model_beat = frame_beat;
				model_in_frame = !frame_beat.last;
			end
			// Space flag lags the fill level by the engine register
			model_space_ff = model_space;
			for (int p = 0; p < NP; p++) begin
				model_space[p] = port_link_up[p] &&
					((`FABRIC_QUEUE_DEPTH - exp_q[p].size()) >= `FABRIC_SPACE_THRESHOLD);
			end
		end
	end

	//////////////////////////////////////////////////
	// Per-port protocol checks

	for (genvar p = 0; p < NP; p++) begin : g_port_checks
		// Stalled head beat holds still
		stall_hold: assert property (@(posedge clk_ram_ctl) disable iff (rst)
			port_tx_valid[p] && !port_tx_ready[p] && port_link_up[p]
			|=> port_tx_valid[p] && $stable(port_tx_beat[p]))
			else abort_run($sformatf("Port %0d head beat moved while stalled", p));
		// Dropped link empties the queue
		link_flush: assert property (@(posedge clk_ram_ctl) disable iff (rst)
			$fell(port_link_up[p]) |=> !port_tx_valid[p])
			else abort_run($sformatf("Port %0d still valid after link down", p));
	end

	//////////////////////////////////////////////////
	// Stimulus helpers

	task automatic idle_cycles(input int n);
		repeat (n) @(posedge clk_ram_ctl);
	endtask

	// One frame, idle gaps of up to max_gap cycles between beats
	task automatic send_frame(input int src, input int vlan, input int beats,
		input int max_gap);
		frame_header_t hdr;
		frame_beat_t beat;
		int gap;
		hdr.src_port = src[`FABRIC_PORT_BITS-1:0];
		hdr.vlan = vlan[`FABRIC_VLAN_BITS-1:0];
		for (int b = 0; b < beats; b++) begin
			beat.data = {$random(seed), $random(seed), $random(seed), $random(seed)};
			beat.last = (b == beats - 1);
			@(posedge clk_ram_ctl);
			frame_valid <= 1'b1;
			frame_beat <= beat;
			frame_header <= hdr;
			if (b < beats - 1 && max_gap > 0) begin
				gap = $unsigned($random(seed)) % (max_gap + 1);
				repeat (gap) begin
					@(posedge clk_ram_ctl);
					frame_valid <= 1'b0;
				end
			end
		end
		@(posedge clk_ram_ctl);
		frame_valid <= 1'b0;
	endtask

	task automatic send_random_frames(input int n);
		for (int i = 0; i < n; i++) begin
			send_frame($unsigned($random(seed)) % NP, 10 + $unsigned($random(seed)) % 4,
				1 + $unsigned($random(seed)) % `FABRIC_MAX_FRAME_BEATS, 2);
		end
	endtask

	// Sampled on the falling edge, away from model updates
	task automatic wait_drained(input int limit);
		int cycles;
		bit busy;
		cycles = 0;
		busy = 1'b1;
		while (busy) begin
			@(negedge clk_ram_ctl);
			busy = (port_tx_valid != '0) || (model_wr != '0);
			for (int p = 0; p < NP; p++) begin
				if (exp_q[p].size() != 0) begin
					busy = 1'b1;
				end
			end
			cycles++;
			if (busy && cycles > limit) begin
				abort_run("Timeout waiting for the exit queues to drain");
			end
		end
	endtask

	//////////////////////////////////////////////////
	// Test sequence

	initial begin
		seed = 70;
		sending = 1'b0;
		rst = 1'b1;
		frame_valid = 1'b0;
		frame_beat = '0;
		frame_header = '0;
		// Four VLANs spread over the ports, port 14 a trunk
		for (int p = 0; p < NP; p++) begin
			port_vlan[p] = vlan_t'(10 + p % 4);
		end
		port_trunk = '0;
		port_trunk[14] = 1'b1;
		port_link_up = '1;
		port_tx_ready = '1;

		repeat (2) @(posedge clk_ram_ctl);
		rst <= 1'b0;
		@(negedge clk_ram_ctl);
		assert (port_tx_valid == '0)
			else flag_mismatch("port_tx_valid", port_tx_valid, '0);
		idle_cycles(4);

		// VLAN and trunk forwarding, all ports open
		send_random_frames(24);
		wait_drained(200);

		// Drop, no trunk and no other port on the VLAN
		@(posedge clk_ram_ctl);
		port_trunk <= '0;
		port_vlan[6] <= vlan_t'(200);
		idle_cycles(2);
		out_before = total_beats_out();
		send_frame(2, 99, 3, 1);
		send_frame(6, 200, 4, 0);
		send_frame(9, 99, 1, 0);
		wait_drained(100);
		assert (total_beats_out() == out_before)
			else flag_mismatch("total beats out", total_beats_out(), out_before);
		@(posedge clk_ram_ctl);
		port_trunk[14] <= 1'b1;
		port_vlan[6] <= vlan_t'(12);
		idle_cycles(2);

		// Back-pressure, port 1 stalled while VLAN 11 keeps flowing
		@(posedge clk_ram_ctl);
		port_tx_ready[1] <= 1'b0;
		port13_before = beats_out[13];
		repeat (8) send_frame(5, 11, 4, 0);
		idle_cycles(6);
		// Port 13 is on VLAN 11 and never stalled, so it takes every beat
		assert (beats_out[13] == port13_before + 8 * 4)
			else flag_mismatch("beats out of port 13", beats_out[13],
				port13_before + 8 * 4);
		@(posedge clk_ram_ctl);
		port_tx_ready[1] <= 1'b1;
		wait_drained(200);

		// Random stalls on every port while frames stream in
		sending = 1'b1;
		fork
			begin
				send_random_frames(16);
				sending = 1'b0;
			end
			begin
				while (sending) begin
					@(posedge clk_ram_ctl);
					port_tx_ready <= port_mask_t'($random(seed));
				end
			end
		join
		@(posedge clk_ram_ctl);
		port_tx_ready <= '1;
		wait_drained(300);

		// Link down on port 9 with a stalled frame in its queue
		@(posedge clk_ram_ctl);
		port_tx_ready[9] <= 1'b0;
		send_frame(5, 11, 3, 0);
		idle_cycles(3);
		@(posedge clk_ram_ctl);
		port_link_up[9] <= 1'b0;
		idle_cycles(2);
		// Ready again, so any beat left behind would leave the port
		port_tx_ready[9] <= 1'b1;
		port9_before = beats_out[9];
		repeat (3) send_frame(5, 11, 2, 1);
		wait_drained(200);
		assert (beats_out[9] == port9_before)
			else flag_mismatch("beats out of port 9", beats_out[9], port9_before);

		// Link back, port 9 takes frames again
		@(posedge clk_ram_ctl);
		port_link_up[9] <= 1'b1;
		idle_cycles(4);
		send_frame(5, 11, 4, 0);
		wait_drained(200);
		assert (beats_out[9] == port9_before + 4)
			else flag_mismatch("beats out of port 9", beats_out[9], port9_before + 4);

		$display("all tests passed");
		$finish;
	end

endmodule

// ==== tb.f ====
+incdir+.
fabric_pkg.sv
forwarding_engine.sv
exit_queue.sv
switch_fabric.sv
tb_switch_fabric.sv

// ==== Bender.yml ====
package:
  name: switch_fabric

export_include_dirs:
  - .

sources:
  - files:
      - fabric_pkg.sv
      - forwarding_engine.sv
      - exit_queue.sv
      - switch_fabric.sv
  - target: test
    files:
      - tb_switch_fabric.sv
